// File: lookup_input.txt
# w <addr hex> <key hex: flag|vlan|dst_port|dst_ip> <action hex>
# l <port> <key hex> <expected action hex> <hit 1 or 0>
# entry A at its first index 0x2b
w 2b 006400500a000001 00001001
# entry B at its second index 0x2c, decoy at B's first index 0x13
w 2c 00c801bbc0a80102 00002002
w 13 00c801bbc0a80103 00000bad
# entry E at its first index 0x10, entry F at its second index 0x01
w 10 000100160a000002 00003003
w 01 00c8003508080808 00004004
# lookups, each port holds three
l 0 006400500a000001 00001001 1
l 1 00c801bbc0a80102 00002002 1
# dst_port differs from A, reads E at second index
l 2 006400510a000001 00000000 0
# A with the flag bit set
l 3 806400500a000001 00001001 1
l 0 00c8003508080808 00004004 1
l 1 000100160a000002 00003003 1
l 2 80c801bbc0a80102 00002002 1
# decoy key hashes to 0x12, never stored there
l 3 00c801bbc0a80103 00000000 0
l 0 006400510a000001 00000000 0
l 1 000100160a000003 00000000 0
l 2 006400500a000001 00001001 1
l 3 00c8003508080808 00004004 1

// File: sources.f
flow_pkg.sv
lookup_pkg.sv
lookup_scheduler.sv
flow_table_mem.sv
action_resolver.sv
flow_lookup_top.sv
flow_lookup_sva.sv
tb_flow_lookup.sv

// File: run_sim.sh
#!/bin/sh
# build and run the flow lookup testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
   --top-module tb_flow_lookup -o sim_flow_lookup
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_flow_lookup)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q "^TEST PASSED$"; then
   exit 0
fi
exit 1

// File: tb_flow_lookup.sv
`timescale 1ns/10ps
`default_nettype none

module tb_flow_lookup
   import flow_pkg::*, lookup_pkg::*;
();

   localparam int NUM_PORTS    = 4;
   localparam int TABLE_BITS   = 6;
   localparam int MAX_LK       = 64;
   localparam int HALF_PERIOD  = 50;
   localparam int DRAIN_CYCLES = 8;

   logic                      asclk;
   logic                      aresetn;
   logic [NUM_PORTS-1:0]      req;
   flow_key_u [NUM_PORTS-1:0] keys;
   logic [NUM_PORTS-1:0]      ack;
   logic [NUM_PORTS-1:0]      done;
   flow_action_t              action_out;
   logic                      host_wr;
   logic [TABLE_BITS-1:0]     host_addr;
   flow_entry_t               host_entry;
   hit_counters_t             counters;
   count_t [NUM_PORTS-1:0]    dropped;

   // --------------------
   // stimulus from the data file
   logic [TABLE_BITS-1:0] wr_addr [MAX_LK];
   flow_entry_t           wr_entry [MAX_LK];
   int                    n_wr;
   logic [KEY_W-1:0]      lk_key [MAX_LK];
   flow_action_t          lk_act [MAX_LK];
   int                    n_lk;
   int                    exp_hits;
   int                    exp_misses;
   int                    exp_drop [NUM_PORTS];

   // per-port progress, lookups complete in issue order
   int port_list [NUM_PORTS][MAX_LK];
   int n_port [NUM_PORTS];
   int issue_ptr [NUM_PORTS];
   int done_ptr [NUM_PORTS];
   int ack_cyc [MAX_LK];
   int n_done;
   int cyc;

   int value_errors;
   int other_errors;
   bit load_ok;
   bit load_done;

   initial asclk = 1'b0;
   always #HALF_PERIOD asclk = ~asclk;

   flow_lookup_top #(
      .NUM_PORTS  (NUM_PORTS),
      .TABLE_BITS (TABLE_BITS)
   ) i_flow_lookup_top (
      .asclk      (asclk),
      .aresetn    (aresetn),
      .req        (req),
      .keys       (keys),
      .ack        (ack),
      .done       (done),
      .action_out (action_out),
      .host_wr    (host_wr),
      .host_addr  (host_addr),
      .host_entry (host_entry),
      .counters   (counters),
      .dropped    (dropped)
   );

   bind flow_lookup_top flow_lookup_sva #(
      .NUM_PORTS (NUM_PORTS)
   ) i_flow_lookup_sva (
      .asclk   (asclk),
      .aresetn (aresetn),
      .ack     (ack),
      .done    (done)
   );

   task automatic report_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      $display("error %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
   endtask

   // w lines are table writes, l lines are lookups, # lines are skipped
   task automatic load_input();
      int               fd;
      int               code;
      int               ch;
      logic [7:0]       tag;
      logic [7:0]       addr;
      logic [KEY_W-1:0] key;
      flow_action_t     act;
      int               port;
      int               hit;
      fd = $fopen("lookup_input.txt", "r");
      if (fd == 0) begin
         $display("cannot open lookup_input.txt");
         load_ok = 1'b0;
         return;
      end
      load_ok = 1'b1;
      while (load_ok) begin
         code = $fscanf(fd, " %c", tag);
         if (code != 1) break;
         if (tag == "#") begin
            ch = $fgetc(fd);
            while (ch != 10 && ch != -1) begin
               ch = $fgetc(fd);
            end
         end else if (tag == "w") begin
            code = $fscanf(fd, " %h %h %h", addr, key, act);
            if (code != 3 || n_wr >= MAX_LK) begin
               $display("malformed write line in lookup_input.txt");
               load_ok = 1'b0;
            end else begin
               wr_addr[n_wr]                = addr[TABLE_BITS-1:0];
               wr_entry[n_wr].key.raw       = key;
               wr_entry[n_wr].action        = act;
               n_wr++;
            end
         end else if (tag == "l") begin
            code = $fscanf(fd, " %d %h %h %d", port, key, act, hit);
            if (code != 4 || port < 0 || port >= NUM_PORTS || n_lk >= MAX_LK) begin
               $display("malformed lookup line in lookup_input.txt");
               load_ok = 1'b0;
            end else begin
               lk_key[n_lk] = key;
               lk_act[n_lk] = act;
               port_list[port][n_port[port]] = n_lk;
               n_port[port]++;
               if (hit != 0) begin
                  exp_hits++;
               end else begin
                  exp_misses++;
                  exp_drop[port]++;
               end
               n_lk++;
            end
         end else begin
            $display("unknown line tag in lookup_input.txt");
            load_ok = 1'b0;
         end
      end
      $fclose(fd);
   endtask

   // every field tied to the address, vlan 0x7fff never used by a lookup
   function automatic flow_entry_t fill_entry(input logic [TABLE_BITS-1:0] addr);
      flow_entry_t e;
      e.key.raw = {1'b0, 15'h7fff, 10'h3ff, addr, 26'h0, addr};
      e.action  = {26'h2aa_aaaa, addr};
      return e;
   endfunction

   // called just after a rising edge, returns just after the next one
   task automatic write_entry(input logic [TABLE_BITS-1:0] addr, input flow_entry_t entry);
      host_wr    = 1'b1;
      host_addr  = addr;
      host_entry = entry;
      @(posedge asclk);
      #1;
   endtask

   task automatic drive_ports();
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (issue_ptr[p] < n_port[p]) begin
            req[p]      = 1'b1;
            keys[p].raw = lk_key[port_list[p][issue_ptr[p]]];
         end else begin
            req[p] = 1'b0;
         end
      end
   endtask

   task automatic observe_ack();
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (ack[p]) begin
            if (issue_ptr[p] >= n_port[p]) begin
               $display("port %0d acked with no request pending", p);
               other_errors++;
            end else begin
               ack_cyc[port_list[p][issue_ptr[p]]] = cyc;
               issue_ptr[p]++;
            end
         end
      end
   endtask

   task automatic observe_done();
      int idx;
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (done[p]) begin
            if (done_ptr[p] >= issue_ptr[p]) begin
               $display("done on port %0d with no lookup in flight", p);
               other_errors++;
            end else begin
               idx = port_list[p][done_ptr[p]];
               if (action_out !== lk_act[idx]) begin
                  report_value($sformatf("lookup %0d action", idx), lk_act[idx], action_out);
               end
               if (cyc - ack_cyc[idx] != 4) begin
                  report_value($sformatf("lookup %0d latency", idx), 32'd4,
                               32'(cyc - ack_cyc[idx]));
               end
               done_ptr[p]++;
               n_done++;
            end
         end
      end
   endtask

   task automatic step_cycle();
      @(posedge asclk);
      #1;
      cyc++;
      observe_ack();
      observe_done();
      drive_ports();
   endtask

   task automatic check_counters();
      if (counters.exact_hit !== count_t'(exp_hits)) begin
         report_value("exact_hit", exp_hits, counters.exact_hit);
      end
      if (counters.exact_miss !== count_t'(exp_misses)) begin
         report_value("exact_miss", exp_misses, counters.exact_miss);
      end
      if (counters.exact_hit + counters.exact_miss !== count_t'(n_lk)) begin
         report_value("hit plus miss", n_lk, counters.exact_hit + counters.exact_miss);
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (dropped[p] !== count_t'(exp_drop[p])) begin
            report_value($sformatf("dropped port %0d", p), exp_drop[p], dropped[p]);
         end
      end
   endtask

   // --------------------
   // main sequence
   initial begin : main
      aresetn    = 1'b0;
      req        = '0;
      keys       = '0;
      host_wr    = 1'b0;
      host_addr  = '0;
      host_entry = '0;
      load_input();
      if (!load_ok) begin
         $display("stimulus file could not be read");
         $display("TEST FAILED");
         $finish;
      end else begin
         load_done = 1'b1;
         repeat (5) @(posedge asclk);
         #1;
         aresetn = 1'b1;
         for (int a = 0; a < 2 ** TABLE_BITS; a++) begin
            write_entry(TABLE_BITS'(a), fill_entry(TABLE_BITS'(a)));
         end
         for (int i = 0; i < n_wr; i++) begin
            write_entry(wr_addr[i], wr_entry[i]);
         end
         host_wr = 1'b0;
         drive_ports();
         while (n_done < n_lk) begin
            step_cycle();
         end
         // stray done or ack pulses would show up here
         repeat (DRAIN_CYCLES) step_cycle();
         check_counters();
         $display("lookups %0d, value errors %0d, other errors %0d",
                  n_lk, value_errors, other_errors);
         if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
         end else begin
            $display("TEST FAILED");
         end
         $finish;
      end
   end

   initial begin : watchdog
      int limit;
      wait (load_done);
      limit = (n_wr + n_lk) * 20 + 50;
      repeat (limit) @(posedge asclk);
      $display("timeout after %0d cycles, lookups still outstanding", limit);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: flow_lookup_sva.sv
`timescale 1ns/10ps
`default_nettype none

module flow_lookup_sva #(
   parameter int NUM_PORTS = 4
) (
   input wire logic                 asclk,
   input wire logic                 aresetn,
   input wire logic [NUM_PORTS-1:0] ack,
   input wire logic [NUM_PORTS-1:0] done
);

   // --------------------
   // one grant and one result per cycle at most
   a_ack_onehot: assert property (@(posedge asclk) disable iff (!aresetn) $onehot0(ack))
      else $error("ack has more than one bit set");

   a_done_onehot: assert property (@(posedge asclk) disable iff (!aresetn) $onehot0(done))
      else $error("done has more than one bit set");

   // --------------------
   // per port timing
   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
      // fixed four stage pipeline from grant to result
      a_done_latency: assert property (@(posedge asclk) disable iff (!aresetn)
         done[p] == $past(ack[p], 4))
         else $error("done on port %0d does not follow its ack by 4 cycles", p);

      a_no_back_to_back: assert property (@(posedge asclk) disable iff (!aresetn)
         ack[p] |=> !ack[p])
         else $error("port %0d acked on two cycles in a row", p);
   end

endmodule

`default_nettype wire

// File: flow_lookup_top.sv
`timescale 1ns/10ps
`default_nettype none

module flow_lookup_top
   import flow_pkg::*, lookup_pkg::*;
#(
   parameter int NUM_PORTS  = 4,
   parameter int TABLE_BITS = 6
) (
   input  wire logic                      asclk,
   input  wire logic                      aresetn,
   // lookup ports
   input  wire logic [NUM_PORTS-1:0]      req,
   input  wire flow_key_u [NUM_PORTS-1:0] keys,
   output logic [NUM_PORTS-1:0]           ack,
   output logic [NUM_PORTS-1:0]           done,
   output flow_action_t                   action_out,
   // host table writes
   input  wire logic                      host_wr,
   input  wire logic [TABLE_BITS-1:0]     host_addr,
   input  wire flow_entry_t               host_entry,
   // statistics
   output hit_counters_t                  counters,
   output count_t [NUM_PORTS-1:0]         dropped
);

   logic [TABLE_BITS-1:0] rd_idx0;
   logic [TABLE_BITS-1:0] rd_idx1;
   lookup_token_t         token;
   flow_entry_t           entry0;
   flow_entry_t           entry1;

   // --------------------
   // arbiter and hash
   lookup_scheduler #(
      .NUM_PORTS  (NUM_PORTS),
      .TABLE_BITS (TABLE_BITS)
   ) i_lookup_scheduler (
      .asclk   (asclk),
      .aresetn (aresetn),
      .req     (req),
      .keys    (keys),
      .ack     (ack),
      .rd_idx0 (rd_idx0),
      .rd_idx1 (rd_idx1),
      .token   (token)
   );

   // exact-match table
   flow_table_mem #(
      .TABLE_BITS (TABLE_BITS)
   ) i_flow_table_mem (
      .asclk      (asclk),
      .host_wr    (host_wr),
      .host_addr  (host_addr),
      .host_entry (host_entry),
      .rd_idx0    (rd_idx0),
      .rd_idx1    (rd_idx1),
      .entry0     (entry0),
      .entry1     (entry1)
   );

   // compare, action out and counters
   action_resolver #(
      .NUM_PORTS (NUM_PORTS)
   ) i_action_resolver (
      .asclk      (asclk),
      .aresetn    (aresetn),
      .token      (token),
      .entry0     (entry0),
      .entry1     (entry1),
      .action_out (action_out),
      .done       (done),
      .counters   (counters),
      .dropped    (dropped)
   );

endmodule

`default_nettype wire

// File: action_resolver.sv
`timescale 1ns/10ps
`default_nettype none

module action_resolver
   import flow_pkg::*, lookup_pkg::*;
#(
   parameter int NUM_PORTS = 4
) (
   input  wire logic                  asclk,
   input  wire logic                  aresetn,
   input  wire lookup_token_t         token,
   input  wire flow_entry_t           entry0,
   input  wire flow_entry_t           entry1,
   output flow_action_t               action_out,
   output logic [NUM_PORTS-1:0]       done,
   output hit_counters_t              counters,
   output count_t [NUM_PORTS-1:0]     dropped
);

   logic                     valid_s3;
   logic [MAX_PORT_BITS-1:0] port_s3;
   logic                     match0_s3;
   logic                     match1_s3;
   flow_action_t             action0_s3;
   flow_action_t             action1_s3;

   logic                     hit_s3;
   flow_action_t             sel_action;
   logic [NUM_PORTS-1:0]     port_vec;

   // vlan, dst_port and dst_ip must all agree
   // the flag bit is a don't-care
   function automatic logic key_match(input flow_key_u stored, input flow_key_u probe);
      return {stored.fields.vlan, stored.fields.dst_port, stored.fields.dst_ip} ==
             {probe.fields.vlan, probe.fields.dst_port, probe.fields.dst_ip};
   endfunction

   // --------------------
   // T3 compare stage
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         valid_s3 <= 1'b0;
      end else begin
         valid_s3 <= token.valid;
      end
   end

   // match flags are only set for a valid token
   always_ff @(posedge asclk) begin
      port_s3    <= token.port;
      match0_s3  <= token.valid && key_match(entry0.key, token.key);
      match1_s3  <= token.valid && key_match(entry1.key, token.key);
      action0_s3 <= entry0.action;
      action1_s3 <= entry1.action;
   end

   // --------------------
   // first matching index wins
   always_comb begin
      hit_s3     = match0_s3 || match1_s3;
      sel_action = ACTION_DROP;
      if (match0_s3) begin
         sel_action = action0_s3;
      end else if (match1_s3) begin
         sel_action = action1_s3;
      end
   end

   // one-hot of the requesting port
   always_comb begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         port_vec[p] = valid_s3 && (port_s3 == MAX_PORT_BITS'(p));
      end
   end

   // T4 registers action, done pulse and global counts
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         action_out <= '0;
         done       <= '0;
         counters   <= '0;
      end else begin
         action_out <= sel_action;
         done       <= port_vec;
         if (hit_s3) begin
            counters.exact_hit <= counters.exact_hit + 1'b1;
         end
         if (valid_s3 && !hit_s3) begin
            counters.exact_miss <= counters.exact_miss + 1'b1;
         end
      end
   end

   // per-port drop counts
   // every miss is a dropped packet
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         dropped <= '0;
      end else begin
         for (int p = 0; p < NUM_PORTS; p++) begin
            if (port_vec[p] && !hit_s3) begin
               dropped[p] <= dropped[p] + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: flow_table_mem.sv
`timescale 1ns/10ps
`default_nettype none

module flow_table_mem
   import flow_pkg::*;
#(
   parameter int TABLE_BITS = 6
) (
   input  wire logic                  asclk,
   input  wire logic                  host_wr,
   input  wire logic [TABLE_BITS-1:0] host_addr,
   input  wire flow_entry_t           host_entry,
   input  wire logic [TABLE_BITS-1:0] rd_idx0,
   input  wire logic [TABLE_BITS-1:0] rd_idx1,
   output flow_entry_t                entry0,
   output flow_entry_t                entry1
);

   localparam int DEPTH = 2 ** TABLE_BITS;

   flow_entry_t mem [DEPTH];

   // --------------------
   // host write port
   always_ff @(posedge asclk) begin
      if (host_wr) begin
         mem[host_addr] <= host_entry;
      end
   end

   // --------------------
   // two lookup read ports, registered
   // read-first, a colliding write shows up one cycle later
   always_ff @(posedge asclk) begin
      entry0 <= mem[rd_idx0];
      entry1 <= mem[rd_idx1];
   end

endmodule

`default_nettype wire

// File: lookup_scheduler.sv
`timescale 1ns/10ps
`default_nettype none

module lookup_scheduler
   import flow_pkg::*, lookup_pkg::*;
#(
   parameter int NUM_PORTS  = 4,
   parameter int TABLE_BITS = 6
) (
   input  wire logic                        asclk,
   input  wire logic                        aresetn,
   input  wire logic [NUM_PORTS-1:0]        req,
   input  wire flow_key_u [NUM_PORTS-1:0]   keys,
   output logic [NUM_PORTS-1:0]             ack,
   output logic [TABLE_BITS-1:0]            rd_idx0,
   output logic [TABLE_BITS-1:0]            rd_idx1,
   output lookup_token_t                    token
);

   // number of TABLE_BITS slices covering the key, last one padded
   localparam int NSLICES = (KEY_W + TABLE_BITS - 1) / TABLE_BITS;

   logic [MAX_PORT_BITS-1:0]      rr_cnt;
   logic [NUM_PORTS-1:0]          grant_vec;
   logic [MAX_PORT_BITS-1:0]      grant_port;
   flow_key_u                     grant_key;

   logic [MAX_PORT_BITS-1:0]      port_q;
   flow_key_u                     key_q;

   flow_key_u                     hash_key;
   logic [NSLICES*TABLE_BITS-1:0] hash_src;
   logic [TABLE_BITS-1:0]         idx0;
   logic [TABLE_BITS-1:0]         idx1;

   lookup_token_t                 token_h;

   // --------------------
   // rotating priority
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         rr_cnt <= '0;
      end else if (rr_cnt == MAX_PORT_BITS'(NUM_PORTS - 1)) begin
         rr_cnt <= '0;
      end else begin
         rr_cnt <= rr_cnt + 1'b1;
      end
   end

   // first requester at or above rr_cnt, wrapping
   // a port acked this cycle sits out the next grant
   always_comb begin : arb
      int p;
      grant_vec  = '0;
      grant_port = '0;
      grant_key  = keys[0];
      for (int i = 0; i < NUM_PORTS; i++) begin
         p = (int'(rr_cnt) + i) % NUM_PORTS;
         if (grant_vec == '0 && req[p] && !ack[p]) begin
            grant_vec[p] = 1'b1;
            grant_port   = MAX_PORT_BITS'(p);
            grant_key    = keys[p];
         end
      end
   end

   // T0: ack and key capture on the same edge
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         ack <= '0;
      end else begin
         ack <= grant_vec;
      end
   end

   always_ff @(posedge asclk) begin
      port_q <= grant_port;
      key_q  <= grant_key;
   end

   // --------------------
   // hash, flag bit excluded
   always_comb begin
      hash_key              = key_q;
      hash_key.fields.flag  = 1'b0;
      hash_src              = '0;
      hash_src[KEY_W-1:0]   = hash_key.raw;
      idx0                  = '0;
      for (int s = 0; s < NSLICES; s++) begin
         idx0 = idx0 ^ hash_src[s*TABLE_BITS +: TABLE_BITS];
      end
      // second candidate is the mirror bucket
      idx1 = ~idx0;
   end

   // T1: hashed token, drives the table read
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         token_h.valid <= 1'b0;
      end else begin
         token_h.valid <= |ack;
         token_h.port  <= port_q;
         token_h.key   <= key_q;
         token_h.idx0  <= MAX_IDX_W'(idx0);
         token_h.idx1  <= MAX_IDX_W'(idx1);
      end
   end

   assign rd_idx0 = token_h.idx0[TABLE_BITS-1:0];
   assign rd_idx1 = token_h.idx1[TABLE_BITS-1:0];

   // T2: lines up with table read data
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         token.valid <= 1'b0;
      end else begin
         token <= token_h;
      end
   end

endmodule

`default_nettype wire

// File: lookup_pkg.sv
`default_nettype none

package lookup_pkg;

   // --------------------
   // counter width
   localparam int COUNT_W = 32;

   // upper bounds that size the token fields
   localparam int MAX_PORT_BITS = 3;
   localparam int MAX_IDX_W     = 8;

   typedef logic [COUNT_W-1:0] count_t;

   // --------------------
   // one lookup in flight, scheduler to resolver
   // only the low TABLE_BITS of each index reach the table
   typedef struct packed {
      logic                     valid;
      logic [MAX_PORT_BITS-1:0] port;
      flow_pkg::flow_key_u      key;
      logic [MAX_IDX_W-1:0]     idx0;
      logic [MAX_IDX_W-1:0]     idx1;
   } lookup_token_t;

   // global exact-match totals
   typedef struct packed {
      count_t exact_hit;
      count_t exact_miss;
   } hit_counters_t;

endpackage

`default_nettype wire

// File: flow_pkg.sv
`default_nettype none

package flow_pkg;

   // --------------------
   // table word widths
   localparam int KEY_W    = 64;
   localparam int ACTION_W = 32;

   // --------------------
   // key layout, msb first
   // flag is carried along but never takes part in matching
   typedef struct packed {
      logic        flag;
      logic [14:0] vlan;
      logic [15:0] dst_port;
      logic [31:0] dst_ip;
   } flow_fields_t;

   // raw view for hashing, field view for compare
   typedef union packed {
      logic [KEY_W-1:0] raw;
      flow_fields_t     fields;
   } flow_key_u;

   typedef logic [ACTION_W-1:0] flow_action_t;

   // an all-zero action drops the packet
   localparam flow_action_t ACTION_DROP = '0;

   // one table entry, also the host write word
   typedef struct packed {
      flow_key_u    key;
      flow_action_t action;
   } flow_entry_t;

endpackage

`default_nettype wire
